/* hw/blit_bus_pkg.sv */
// ==========================================================
// Blitter VRAM bus types
// ==========================================================

package blit_bus_pkg;

    localparam int WORD_W = 16;             // VRAM data word width
    localparam int ADDR_W = 16;             // VRAM word address width
    localparam int NIB_W  = WORD_W / 4;     // one mask bit per nibble

    // 16-bit VRAM data word
    typedef logic [WORD_W-1:0] word_t;

    // VRAM word address
    typedef logic [ADDR_W-1:0] addr_t;

    // nibble write mask, bit 3 covers data bits 15..12
    typedef logic [NIB_W-1:0] nib_mask_t;

    // request from blitter to VRAM arbiter
    typedef struct packed {
        logic      sel;         // access requested
        logic      wr;          // 1 write, 0 read
        addr_t     addr;        // word address
        nib_mask_t wr_mask;     // nibbles written, writes only
        word_t     data;        // write data
    } vram_req_t;

endpackage

/* hw/blit_reg_pkg.sv */
// ==========================================================
// Blitter register map and sequencer types
// ==========================================================

package blit_reg_pkg;

    localparam int REG_NUM_W = 4;           // register number width
    localparam int LINES_W   = 15;          // line count, stored as count minus one

    // register numbers as seen on the write port
    typedef enum logic [REG_NUM_W-1:0] {
        CTRL  = 4'd0,
        SHIFT = 4'd1,       // edge masks in bits 15..8
        MOD_A = 4'd2,
        MOD_B = 4'd3,
        VAL_T = 4'd4,
        MOD_D = 4'd5,
        SRC_A = 4'd6,       // address, or constant A
        SRC_B = 4'd7,       // address, or constant B
        VAL_C = 4'd8,
        DST_D = 4'd9,
        LINES = 4'd10,
        WORDS = 4'd11       // writing here queues the blit
    } blit_reg_e;

    // CTRL register bits 3..0
    typedef struct packed {
        logic c_use_b;      // bit 3
        logic b_use_a;      // bit 2
        logic b_const;      // bit 1
        logic a_const;      // bit 0
    } blit_ctrl_t;

    // everything one blit needs
    typedef struct packed {
        blit_ctrl_t              ctrl;
        blit_bus_pkg::nib_mask_t l_mask;    // first word of a line
        blit_bus_pkg::nib_mask_t r_mask;    // last word of a line
        blit_bus_pkg::word_t     mod_a;
        blit_bus_pkg::word_t     mod_b;
        blit_bus_pkg::word_t     mod_d;
        blit_bus_pkg::addr_t     src_a;
        blit_bus_pkg::addr_t     src_b;
        blit_bus_pkg::addr_t     dst_d;
        blit_bus_pkg::word_t     val_t;
        blit_bus_pkg::word_t     val_c;
        logic [LINES_W-1:0]      lines;
        blit_bus_pkg::word_t     words;
    } blit_cfg_t;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,          // copy queued blit, load constants
        LINE_BEG,       // reload word count, issue first access
        WAIT_RD_A,
        WAIT_RD_B,
        WAIT_WR_D,
        LINE_END        // add modulos, next line or finish
    } blit_state_e;

endpackage

/* hw/blit_regs.sv */
// ==========================================================
// Blitter configuration registers
// ==========================================================

module blit_regs (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    reg_wr_i,
    input  blit_reg_pkg::blit_reg_e reg_num_i,
    input  blit_bus_pkg::word_t     reg_data_i,
    input  logic                    take_i,
    output blit_reg_pkg::blit_cfg_t cfg_o,
    output logic                    queued_o
);

    import blit_bus_pkg::*;
    import blit_reg_pkg::*;

    blit_cfg_t cfg_q;
    logic      queued_q;
    logic      words_wr;

    assign words_wr = reg_wr_i && (reg_num_i == WORDS);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q    <= '0;
            queued_q <= 1'b0;
        end else begin
            // a WORDS write in the take cycle keeps the flag set
            if (words_wr) begin
                queued_q <= 1'b1;
            end else if (take_i) begin
                queued_q <= 1'b0;
            end

            if (reg_wr_i) begin
                case (reg_num_i)
                    CTRL: begin
                        cfg_q.ctrl <= blit_ctrl_t'(reg_data_i[3:0]);
                    end
                    SHIFT: begin
                        cfg_q.l_mask <= reg_data_i[15:12];
                        cfg_q.r_mask <= reg_data_i[11:8];
                    end
                    MOD_A: begin
                        cfg_q.mod_a <= reg_data_i;
                    end
                    MOD_B: begin
                        cfg_q.mod_b <= reg_data_i;
                    end
                    VAL_T: begin
                        cfg_q.val_t <= reg_data_i;
                    end
                    MOD_D: begin
                        cfg_q.mod_d <= reg_data_i;
                    end
                    SRC_A: begin
                        cfg_q.src_a <= reg_data_i;
                    end
                    SRC_B: begin
                        cfg_q.src_b <= reg_data_i;
                    end
                    VAL_C: begin
                        cfg_q.val_c <= reg_data_i;
                    end
                    DST_D: begin
                        cfg_q.dst_d <= reg_data_i;
                    end
                    LINES: begin
                        cfg_q.lines <= reg_data_i[LINES_W-1:0];     // top bit ignored
                    end
                    WORDS: begin
                        cfg_q.words <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cfg_o    = cfg_q;
    assign queued_o = queued_q;

endmodule

/* hw/blit_sequencer.sv */
// ==========================================================
// Blitter sequencer
// ==========================================================

module blit_sequencer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  blit_reg_pkg::blit_cfg_t cfg_i,
    input  logic                    queued_i,
    output logic                    take_o,
    output logic                    setup_o,
    output logic                    cap_a_o,
    output logic                    cap_b_o,
    output logic                    first_word_o,
    output logic                    last_word_o,
    input  blit_bus_pkg::word_t     wr_data_i,
    input  blit_bus_pkg::nib_mask_t wr_mask_i,
    input  logic                    vram_ack_i,
    output blit_bus_pkg::vram_req_t vram_req_o,
    output logic                    busy_o,
    output logic                    done_o
);

    import blit_bus_pkg::*;
    import blit_reg_pkg::*;

    blit_state_e state_q;
    blit_state_e state_d;
    blit_state_e word_state;        // first access of a word
    blit_state_e after_a_state;     // access following an A read

    logic        sel_q;
    logic        wr_q;
    logic        done_q;
    logic        first_word_q;

    // running copy of the blit
    logic        a_const_q;
    logic        b_const_q;
    word_t       mod_a_q;
    word_t       mod_b_q;
    word_t       mod_d_q;
    addr_t       src_a_q;
    addr_t       src_b_q;
    addr_t       dst_d_q;
    word_t       words_q;
    logic [LINES_W:0] lines_q;      // msb set on underflow marks the last line
    logic [16:0] count_q;           // msb set on underflow marks the last word

    addr_t       req_addr;
    logic        last_line;

    assign last_line   = lines_q[LINES_W];
    assign last_word_o = count_q[16];

    always_comb begin
        word_state    = !a_const_q ? WAIT_RD_A : (!b_const_q ? WAIT_RD_B : WAIT_WR_D);
        after_a_state = !b_const_q ? WAIT_RD_B : WAIT_WR_D;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (queued_i) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                state_d = LINE_BEG;
            end
            LINE_BEG: begin
                state_d = word_state;
            end
            WAIT_RD_A: begin
                if (vram_ack_i) begin
                    state_d = after_a_state;
                end
            end
            WAIT_RD_B: begin
                if (vram_ack_i) begin
                    state_d = WAIT_WR_D;
                end
            end
            WAIT_WR_D: begin
                if (vram_ack_i) begin
                    state_d = last_word_o ? LINE_END : word_state;
                end
            end
            LINE_END: begin
                if (!last_line) begin
                    state_d = LINE_BEG;
                end else if (queued_i) begin
                    state_d = SETUP;            // straight into the queued blit
                end else begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            sel_q        <= 1'b0;
            wr_q         <= 1'b0;
            done_q       <= 1'b0;
            first_word_q <= 1'b0;
        end else begin
            state_q <= state_d;
            sel_q   <= (state_d == WAIT_RD_A) || (state_d == WAIT_RD_B) ||
                       (state_d == WAIT_WR_D);
            wr_q    <= (state_d == WAIT_WR_D);
            done_q  <= (state_q == LINE_END) && last_line;

            if (state_q == SETUP || state_q == LINE_END) begin
                first_word_q <= 1'b1;
            end else if (state_q == WAIT_WR_D && vram_ack_i) begin
                first_word_q <= 1'b0;
            end
        end
    end

    // addresses and counters
    always_ff @(posedge clk) begin
        case (state_q)
            SETUP: begin
                a_const_q <= cfg_i.ctrl.a_const;
                b_const_q <= cfg_i.ctrl.b_const;
                mod_a_q   <= cfg_i.mod_a;
                mod_b_q   <= cfg_i.mod_b;
                mod_d_q   <= cfg_i.mod_d;
                src_a_q   <= cfg_i.src_a;
                src_b_q   <= cfg_i.src_b;
                dst_d_q   <= cfg_i.dst_d;
                words_q   <= cfg_i.words;
                lines_q   <= {1'b0, cfg_i.lines};
            end
            LINE_BEG: begin
                lines_q <= lines_q - {{LINES_W{1'b0}}, 1'b1};     // pre-decrement
                count_q <= {1'b0, words_q} - 17'd1;
            end
            WAIT_RD_A: begin
                if (vram_ack_i) begin
                    src_a_q <= src_a_q + 16'd1;
                end
            end
            WAIT_RD_B: begin
                if (vram_ack_i) begin
                    src_b_q <= src_b_q + 16'd1;
                end
            end
            WAIT_WR_D: begin
                if (vram_ack_i) begin
                    dst_d_q <= dst_d_q + 16'd1;
                    count_q <= count_q - 17'd1;
                end
            end
            LINE_END: begin
                src_a_q <= src_a_q + mod_a_q;
                src_b_q <= src_b_q + mod_b_q;
                dst_d_q <= dst_d_q + mod_d_q;
            end
            default: begin
            end
        endcase
    end

    // address follows the access being waited on
    always_comb begin
        case (state_q)
            WAIT_RD_A: req_addr = src_a_q;
            WAIT_RD_B: req_addr = src_b_q;
            default:   req_addr = dst_d_q;
        endcase
    end

    always_comb begin
        vram_req_o.sel     = sel_q;
        vram_req_o.wr      = wr_q;
        vram_req_o.addr    = req_addr;
        vram_req_o.wr_mask = wr_mask_i;
        vram_req_o.data    = wr_data_i;
    end

    assign take_o       = (state_q == SETUP);
    assign setup_o      = (state_q == SETUP);
    assign cap_a_o      = (state_q == WAIT_RD_A) && vram_ack_i;
    assign cap_b_o      = (state_q == WAIT_RD_B) && vram_ack_i;
    assign first_word_o = first_word_q;
    assign busy_o       = (state_q != IDLE);
    assign done_o       = done_q;

endmodule

/* hw/blit_datapath.sv */
// ==========================================================
// Blitter logic operation and write mask
// ==========================================================

module blit_datapath (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     setup_i,
    input  logic                     cap_a_i,
    input  logic                     cap_b_i,
    input  blit_reg_pkg::blit_cfg_t  cfg_i,
    input  blit_bus_pkg::word_t      vram_data_i,
    input  logic                     first_word_i,
    input  logic                     last_word_i,
    output blit_bus_pkg::word_t      wr_data_o,
    output blit_bus_pkg::nib_mask_t  wr_mask_o
);

    import blit_bus_pkg::*;
    import blit_reg_pkg::*;

    blit_ctrl_t ctrl_q;
    nib_mask_t  l_mask_q;
    nib_mask_t  r_mask_q;
    word_t      val_t_q;
    word_t      val_c_q;
    word_t      val_a;
    word_t      val_b;
    word_t      val_tw;         // val_b ^ val_t, zero nibbles are transparent

    word_t      b_eff;
    word_t      c_eff;
    nib_mask_t  opaque;

    // latched at setup so a queued blit cannot disturb the running one
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ctrl_q   <= '0;
            l_mask_q <= '0;
            r_mask_q <= '0;
        end else if (setup_i) begin
            ctrl_q   <= cfg_i.ctrl;
            l_mask_q <= cfg_i.l_mask;
            r_mask_q <= cfg_i.r_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_i) begin
            val_t_q <= cfg_i.val_t;
            val_c_q <= cfg_i.val_c;
            val_a   <= cfg_i.src_a;                     // constant A, if used
            val_b   <= cfg_i.src_b;                     // constant B, if used
            val_tw  <= cfg_i.src_b ^ cfg_i.val_t;
        end
        if (cap_a_i) begin
            val_a <= vram_data_i;
        end
        if (cap_b_i) begin
            val_b  <= vram_data_i;
            val_tw <= vram_data_i ^ val_t_q;
        end
    end

    assign b_eff     = ctrl_q.b_use_a ? val_a : val_b;
    assign c_eff     = ctrl_q.c_use_b ? val_b : val_c_q;
    assign wr_data_o = (val_a & b_eff) ^ c_eff;

    assign opaque = {|val_tw[15:12], |val_tw[11:8], |val_tw[7:4], |val_tw[3:0]};

    assign wr_mask_o = (first_word_i ? l_mask_q : 4'hf) &
                       (last_word_i  ? r_mask_q : 4'hf) &
                       opaque;

endmodule

/* hw/blitter.sv */
// ==========================================================
// Blitter top level
// ==========================================================

module blitter (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    reg_wr_i,
    input  blit_reg_pkg::blit_reg_e reg_num_i,
    input  blit_bus_pkg::word_t     reg_data_i,
    output logic                    busy_o,
    output logic                    full_o,
    output logic                    done_o,
    output blit_bus_pkg::vram_req_t vram_req_o,
    input  logic                    vram_ack_i,
    input  blit_bus_pkg::word_t     vram_data_i
);

    import blit_bus_pkg::*;
    import blit_reg_pkg::*;

    blit_cfg_t cfg;
    logic      take;
    logic      setup;
    logic      cap_a;
    logic      cap_b;
    logic      first_word;
    logic      last_word;
    word_t     wr_data;
    nib_mask_t wr_mask;

    blit_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .take_i     (take),
        .cfg_o      (cfg),
        .queued_o   (full_o)            // queue flag is the full status
    );

    blit_sequencer u_sequencer (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_i        (cfg),
        .queued_i     (full_o),
        .take_o       (take),
        .setup_o      (setup),
        .cap_a_o      (cap_a),
        .cap_b_o      (cap_b),
        .first_word_o (first_word),
        .last_word_o  (last_word),
        .wr_data_i    (wr_data),
        .wr_mask_i    (wr_mask),
        .vram_ack_i   (vram_ack_i),
        .vram_req_o   (vram_req_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    blit_datapath u_datapath (
        .clk          (clk),
        .reset_i      (reset_i),
        .setup_i      (setup),
        .cap_a_i      (cap_a),
        .cap_b_i      (cap_b),
        .cfg_i        (cfg),
        .vram_data_i  (vram_data_i),
        .first_word_i (first_word),
        .last_word_i  (last_word),
        .wr_data_o    (wr_data),
        .wr_mask_o    (wr_mask)
    );

endmodule

/* test/tb_vram.sv */
// ==========================================================
// Behavioral VRAM model
// ==========================================================

module tb_vram (
    input  logic                    clk,
    input  logic                    reset_i,
    input  blit_bus_pkg::vram_req_t req_i,
    output logic                    ack_o,
    output blit_bus_pkg::word_t     data_o
);

    import blit_bus_pkg::*;

    word_t       mem [0:65535];
    logic [31:0] rng_state;
    logic        active;            // an access is being counted down
    logic [1:0]  wait_left;
    word_t       bit_mask;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        logic [16:0] fill_addr;
        for (fill_addr = 17'd0; fill_addr < 17'h10000; fill_addr++) begin
            mem[fill_addr[15:0]] = fill_addr[15:0] ^ 16'h5a5a;
        end
        rng_state = 32'h37f4aa7a;
        ack_o     = 1'b0;
        data_o    = '0;
        active    = 1'b0;
        wait_left = 2'd0;
    end

    // responses change on the falling edge, the DUT samples them on the rising edge
    always @(negedge clk) begin
        if (reset_i) begin
            ack_o  = 1'b0;
            active = 1'b0;
        end else begin
            if (ack_o) begin                // access completed on the last rising edge
                ack_o  = 1'b0;
                active = 1'b0;
            end
            if (req_i.sel) begin
                if (!active) begin
                    rng_state = xorshift32(rng_state);
                    wait_left = rng_state[1:0];     // 0 to 3 extra cycles
                    active    = 1'b1;
                end
                if (wait_left == 2'd0) begin
                    if (req_i.wr) begin
                        bit_mask = {{4{req_i.wr_mask[3]}}, {4{req_i.wr_mask[2]}},
                                    {4{req_i.wr_mask[1]}}, {4{req_i.wr_mask[0]}}};
                        mem[req_i.addr] = (mem[req_i.addr] & ~bit_mask) |
                                          (req_i.data & bit_mask);
                    end else begin
                        data_o = mem[req_i.addr];
                    end
                    ack_o = 1'b1;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

endmodule

/* test/tb_blitter.sv */
// ==========================================================
// Blitter testbench
// ==========================================================

module tb_blitter;

    import blit_bus_pkg::*;
    import blit_reg_pkg::*;

    localparam int TRACE_LEN = 256;

    logic      clk;
    logic      reset_i;
    logic      reg_wr_i;
    blit_reg_e reg_num_i;
    word_t     reg_data_i;
    logic      busy_o;
    logic      full_o;
    logic      done_o;
    vram_req_t vram_req_o;
    logic      vram_ack_i;
    word_t     vram_data_i;

    word_t     trace [0:TRACE_LEN-1];
    int        errors;
    int        checks;
    int        test_errors;
    int        tests_run;
    int        limit_cycles;

    blitter UUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_num_i   (reg_num_i),
        .reg_data_i  (reg_data_i),
        .busy_o      (busy_o),
        .full_o      (full_o),
        .done_o      (done_o),
        .vram_req_o  (vram_req_o),
        .vram_ack_i  (vram_ack_i),
        .vram_data_i (vram_data_i)
    );

    tb_vram u_vram (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (vram_req_o),
        .ack_o   (vram_ack_i),
        .data_o  (vram_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string what, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, expected);
        end
    endtask

    // record: 4 name words, mode, 12 registers, pair count, pairs
    function automatic int record_end(input int p);
        return p + 18 + 2 * int'(trace[p + 17]);
    endfunction

    function automatic int cycle_budget(input int n_tests);
        int p;
        int t;
        int sum;
        p   = 1;
        sum = 200;
        for (t = 0; t < n_tests; t++) begin
            sum += (int'(trace[p + 15]) + 1) * (int'(trace[p + 16]) + 1) * 12;
            p = record_end(p);
        end
        return sum;
    endfunction

    task automatic report(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic string trace_name(input int p);
        return $sformatf("%s", {trace[p], trace[p + 1], trace[p + 2], trace[p + 3]});
    endfunction

    // called on a falling edge, returns on the next one
    task automatic write_reg(input blit_reg_e num, input word_t data);
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(negedge clk);
        reg_wr_i   = 1'b0;
    endtask

    task automatic load_regs(input int p);
        int r;
        for (r = 0; r < 12; r++) begin
            write_reg(blit_reg_e'(r), trace[p + 5 + r]);    // WORDS goes last
        end
    endtask

    task automatic check_memory(input int p);
        int    i;
        int    n;
        addr_t addr;
        n = int'(trace[p + 17]);
        for (i = 0; i < n; i++) begin
            addr = trace[p + 18 + 2 * i];
            check_word($sformatf("mem[%h]", addr), u_vram.mem[addr], trace[p + 19 + 2 * i]);
        end
    endtask

    task automatic run_single(input int p);
        load_regs(p);
        check_flag("full_o", full_o, 1'b1);
        while (done_o !== 1'b1) begin
            @(negedge clk);
        end
        check_flag("busy_o", busy_o, 1'b0);     // nothing queued behind
        @(negedge clk);
        check_flag("done_o", done_o, 1'b0);     // one-cycle pulse
    endtask

    // second blit is written while the first runs
    task automatic run_queued(input int pa, input int pb);
        int dones;
        load_regs(pa);
        while (full_o === 1'b1) begin
            @(negedge clk);
        end
        check_flag("busy_o", busy_o, 1'b1);
        load_regs(pb);
        dones = 0;
        while (dones < 2) begin
            if (dones == 0) begin
                check_flag("full_o", full_o, 1'b1);
            end else if (done_o !== 1'b1) begin
                check_flag("busy_o", busy_o, 1'b1);
            end
            if (done_o === 1'b1) begin
                dones++;
            end
            if (dones < 2) begin
                @(negedge clk);
            end
        end
        check_flag("busy_o", busy_o, 1'b0);
    endtask

    initial begin
        int n_tests;
        int p;
        int q;
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_num_i   = CTRL;
        reg_data_i  = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        tests_run   = 0;
        $readmemh("test/blit_trace.txt", trace);
        if ($isunknown(trace[0])) begin
            $display("could not read the trace file test/blit_trace.txt");
            errors++;
            n_tests = 0;
        end else begin
            n_tests = int'(trace[0]);
        end
        limit_cycles = cycle_budget(n_tests);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("full_o", full_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("vram_req_o.sel", vram_req_o.sel, 1'b0);
        check_flag("vram_req_o.wr", vram_req_o.wr, 1'b0);
        report("reset");

        p = 1;
        while (n_tests > 0) begin
            if (trace[p + 4][0]) begin
                q = record_end(p);
                run_queued(p, q);
                check_memory(p);
                report(trace_name(p));
                check_memory(q);
                report(trace_name(q));
                p = record_end(q);
                n_tests -= 2;
            end else begin
                run_single(p);
                check_memory(p);
                report(trace_name(p));
                p = record_end(p);
                n_tests -= 1;
            end
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: no end of the tests after %0d cycles, a blit hung", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* test/blit_trace.txt */
// name (4 ascii words), mode (1 = next test queued behind), then CTRL SHIFT MOD_A MOD_B
// VAL_T MOD_D SRC_A SRC_B VAL_C DST_D LINES WORDS, pair count, then address and word pairs
0007
// fill: constants, 3 lines of 4 words, gaps between lines untouched
6669 6c6c 2020 2020 0000
0003 ff00 0000 0000 0000 0004 ffff ffff 1234 1000 0002 0003
0009 1000 edcb 1003 edcb 1004 4a5e 1007 4a5d 1008 edcb
     100b edcb 1010 edcb 1013 edcb 1014 4a4e
// copy: D = A xor C over 2 lines, mod_a 2, mod_d 1
636f 7079 2020 2020 0000
0006 ff00 0002 0000 ffff 0001 2000 0000 00ff 3000 0001 0001
0005 3000 7aa5 3001 7aa4 3002 6a58 3003 7aa1 3004 7aa0
// xor_b: A and B read, B' = A, C' = B
786f 725f 6220 2020 0000
000c ff00 0000 0000 0000 0000 2100 4003 1111 3100 0000 0001
0003 3100 6103 3101 6105 3102 6b58
// transp: nibbles of B equal to T keep the old memory value
7472 616e 7370 2020 0000
0001 ff00 0000 0000 1a5b 0000 ffff 5000 0f0f 3200 0000 0001
0002 3200 0855 3201 085b
// edges: left mask 0011, right mask 1100
6564 6765 7320 2020 0000
0003 3c00 0000 0000 0000 0005 ffff ffff 0000 3300 0001 0002
0006 3300 69ff 3301 ffff 3302 ff58 3308 69ff 3309 ffff 330a ff50
// queue_a runs while queue_b is written behind it
7175 6575 655f 6120 0001
0006 ff00 0000 0000 ffff 0000 2200 0000 0000 3400 0003 0003
0004 3400 785a 3407 785d 340f 7855 3410 6e4a
7175 6575 655f 6220 0000
0003 ff00 0000 0000 0000 0000 00ff ffff a000 3500 0000 0001
0003 3500 a0ff 3501 a0ff 3502 6f58

/* vlog.f */
hw/blit_bus_pkg.sv
hw/blit_reg_pkg.sv
hw/blit_regs.sv
hw/blit_sequencer.sv
hw/blit_datapath.sv
hw/blitter.sv
test/tb_vram.sv
test/tb_blitter.sv

/* run.sh */
#!/bin/sh
# compile and run the blitter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module tb_blitter
./obj_dir/Vtb_blitter > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
